// ==== test/cuStim.mem ====
// ir icc wim nPcSel rfWrites memWrites trapType cwp
// expected columns hold what is seen up to the fetch that follows the instruction
40000010 0 00000000 1 1 0 0 00
03000400 0 00000000 0 1 0 0 00
82800001 0 00000000 0 1 0 0 00
81C3E008 0 00000000 2 1 0 0 00
C2002004 0 00000000 0 1 0 0 00
C2202004 0 00000000 0 0 1 0 00
9DE3BFA0 0 00000001 0 1 0 0 1F
9DE3BFA0 0 80000000 0 1 0 0 1E
81E80000 0 00000001 0 1 0 0 1F
00800008 0 00000000 0 0 0 0 1F
04800008 8 00000000 1 0 0 0 1F
08800008 0 00000000 0 0 0 0 1F
0C800008 8 00000000 1 0 0 0 1F
10800008 0 00000000 1 0 0 0 1F
14800008 A 00000000 1 0 0 0 1F
18800008 1 00000000 0 0 0 0 1F
1C800008 8 00000000 0 0 0 0 1F
81E80000 0 40000000 0 1 0 0 00
9DE3BFA0 0 00000002 0 1 0 0 1F
8BD02001 0 00000000 0 0 0 0 1F
8FD02001 D 00000000 0 0 0 0 1F
93D02001 4 00000000 0 0 0 0 1F
97D02001 9 00000000 0 0 0 0 1F
83D02001 4 00000000 3 2 0 3 00
87D02001 2 00000000 3 2 0 3 00
9BD02001 8 00000000 3 2 0 3 00
9FD02001 0 00000000 3 2 0 3 00
9DE3BFA0 0 00000000 0 1 0 0 1F
9DE3BFA0 0 40000000 3 2 0 1 00
81E80000 0 00000002 3 2 0 2 00
00000000 0 00000000 3 2 0 4 00

// ==== src.f ====
logic/cuPkg.sv
logic/instrDecode.sv
logic/windowControl.sv
logic/trapQueue.sv
logic/controlSequencer.sv
logic/controlUnit.sv
test/controlUnitTb.sv

// ==== Makefile ====
TOP = controlUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module controlUnit
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// ==== test/controlUnitTb.sv ====
// Testbench for the control unit with memory responder, stimulus reader and result checks
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb import cuPkg::*; ();

        localparam int nVectors   = 31;
        localparam int cycleLimit = nVectors * 40 + 100;

        logic      Clk;
        logic      rstN;
        word_t     ir;
        icc_t      icc;
        word_t     wim;
        logic      mfc;
        logic      mfa;
        logic      memWrite;
        logic      irLoad;
        logic      pcLoad;
        logic      nPcLoad;
        logic      rfWrite;
        logic      trapEnter;
        nPcSel_t   nPcSel;
        cwp_t      cwp;
        logic      supervisor;
        trapType_t trapType;

        word_t     stim [0:nVectors * 8 - 1];     // Eight columns per instruction
        logic [31:0] lcgState = 32'd66799;
        int        cycleCount = 0;
        int        curIdx = 0;
        int        rfCount;
        int        memCount;
        int        nPcCount;
        int        pcCount;
        int        irCount;
        int        accCount;
        bit        pcLoadSeen;
        nPcSel_t   lastSel;
        trapType_t lastTrap;
        cwp_t      trapCwp;
        cwp_t      prevCwp = '0;
        int        selErrors = 0;
        int        trapErrors = 0;
        int        cwpErrors = 0;
        int        countErrors = 0;
        int        firstMfa;
        bit        fetchSeen;

        controlUnit dut
        (
                .Clk        (Clk),
                .rstN       (rstN),
                .ir         (ir),
                .icc        (icc),
                .wim        (wim),
                .mfc        (mfc),
                .mfa        (mfa),
                .memWrite   (memWrite),
                .irLoad     (irLoad),
                .pcLoad     (pcLoad),
                .nPcLoad    (nPcLoad),
                .rfWrite    (rfWrite),
                .trapEnter  (trapEnter),
                .nPcSel     (nPcSel),
                .cwp        (cwp),
                .supervisor (supervisor),
                .trapType   (trapType)
        );

        initial
        begin
                Clk = 1'b0;
                forever #10 Clk = ~Clk;
        end

        function automatic int nextDelay();
                lcgState = lcgState * 32'd1103515245 + 32'd12345;
                return int'(lcgState[17:16]);             // 0 to 3 cycles
        endfunction

        task automatic checkNPcSel(input string name, input nPcSel_t got, input nPcSel_t exp);
                if (got !== exp)
                begin
                        selErrors++;
                        $display("Fail %s in vector %0d: got %h, expected %h",
                                 name, curIdx, got, exp);
                end
        endtask

        task automatic checkTrapType(input string name, input trapType_t got,
                                     input trapType_t exp);
                if (got !== exp)
                begin
                        trapErrors++;
                        $display("Fail %s in vector %0d: got %h, expected %h",
                                 name, curIdx, got, exp);
                end
        endtask

        task automatic checkCwp(input string name, input cwp_t got, input cwp_t exp);
                if (got !== exp)
                begin
                        cwpErrors++;
                        $display("Fail %s in vector %0d: got %h, expected %h",
                                 name, curIdx, got, exp);
                end
        endtask

        task automatic checkCount(input string name, input int got, input int exp);
                if (got !== exp)
                begin
                        countErrors++;
                        $display("Fail %s in vector %0d: got %h, expected %h",
                                 name, curIdx, got, exp);
                end
        endtask

        // Mid-cycle look at the outputs, tallying this instruction's pulses
        task automatic sampleCycle();
                @(negedge Clk);
                if (rfWrite)
                        rfCount++;
                if (irLoad)
                        irCount++;
                if (pcLoad)
                        pcCount++;
                if (mfa && mfc && memWrite)
                        memCount++;
                if (nPcLoad)
                begin
                        nPcCount++;
                        lastSel = nPcSel;
                        checkCount("pcLoad before nPcLoad", int'(pcLoadSeen), 1);
                end
                if (trapEnter)
                begin
                        lastTrap = trapType;
                        trapCwp  = cwp;
                end
                pcLoadSeen = pcLoad;
        endtask

        // Completes the access whose mfa was just seen
        task automatic answerAccess(input bit fetch);
                repeat (nextDelay())
                begin
                        sampleCycle();
                        checkCount("mfa held", int'(mfa), 1);
                end
                @(posedge Clk);
                #2;
                mfc = 1'b1;
                if (fetch)
                begin
                        ir       = stim[curIdx * 8];
                        icc      = icc_t'(stim[curIdx * 8 + 1][3:0]);
                        wim      = stim[curIdx * 8 + 2];
                        rfCount  = 0;
                        memCount = 0;
                        nPcCount = 0;
                        pcCount  = 0;
                        irCount  = 0;
                        accCount = 0;
                        lastSel  = nPcIncrement;
                        lastTrap = ttNone;
                end
                else
                        accCount++;
                sampleCycle();
                checkCount("mfa held", int'(mfa), 1);
                @(posedge Clk);
                #2;
                mfc = 1'b0;
                sampleCycle();                            // Cycle after mfc
                checkCount("mfa after mfc", int'(mfa), 0);
                checkCount("irLoad after mfc", int'(irLoad), int'(fetch));
        endtask

        task automatic checkResults();
                int        base;
                trapType_t expTrap;
                int        expNPc;
                base    = curIdx * 8;
                expTrap = trapType_t'(stim[base + 6][2:0]);
                expNPc  = (expTrap == ttSoftware) ? 2 : 1;   // Ticc loads nPC before trap entry
                checkNPcSel("nPcSel", lastSel, nPcSel_t'(stim[base + 3][1:0]));
                checkCount("rfWrite count", rfCount, int'(stim[base + 4]));
                checkCount("memWrite count", memCount, int'(stim[base + 5]));
                checkCount("memory accesses", accCount, (stim[base][31:30] == 2'b11) ? 1 : 0);
                checkCount("irLoad count", irCount, 1);
                checkCount("pcLoad count", pcCount, expNPc);
                checkCount("nPcLoad count", nPcCount, expNPc);
                checkTrapType("trapType", lastTrap, expTrap);
                checkCwp("cwp", cwp, cwp_t'(stim[base + 7][4:0]));
                if (expTrap == ttOverflow || expTrap == ttUnderflow)
                        checkCwp("cwp at trap entry", trapCwp, prevCwp);
                if (expTrap != ttNone)
                        checkCount("supervisor", int'(supervisor), 1);
                prevCwp = cwp_t'(stim[base + 7][4:0]);
        endtask

        always @(posedge Clk)
        begin
                cycleCount = cycleCount + 1;
                if (cycleCount == cycleLimit)
                begin
                        $display("Timeout after %0d cycles, the sequencer stopped fetching",
                                 cycleCount);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        initial
        begin
                rstN = 1'b0;
                ir   = '0;
                icc  = '0;
                wim  = '0;
                mfc  = 1'b0;
                $readmemh("test/cuStim.mem", stim);
                repeat (2) @(negedge Clk);
                checkCount("reset strobes", int'({mfa, memWrite, irLoad, pcLoad, nPcLoad, rfWrite,
                                                  trapEnter}), 0);
                checkNPcSel("reset nPcSel", nPcSel, nPcIncrement);
                checkCwp("reset cwp", cwp, '0);
                checkCount("reset supervisor", int'(supervisor), 1);
                @(posedge Clk);
                #2;
                rstN = 1'b1;

                firstMfa = 0;
                do
                begin
                        sampleCycle();
                        firstMfa++;
                end
                while (!mfa);
                checkCount("cycles to first mfa", firstMfa, 3);   // Second edge after release

                for (curIdx = 0; curIdx < nVectors; curIdx++)
                begin
                        answerAccess(1'b1);
                        fetchSeen = 1'b0;
                        while (!fetchSeen)
                        begin
                                sampleCycle();
                                if (mfa)
                                begin
                                        if (nPcCount > 0)
                                                fetchSeen = 1'b1;  // Next instruction fetch
                                        else
                                                answerAccess(1'b0);
                                end
                        end
                        checkResults();
                end

                $display("Errors: nPcSel %0d, trapType %0d, cwp %0d, counts %0d",
                         selErrors, trapErrors, cwpErrors, countErrors);
                if (selErrors + trapErrors + cwpErrors + countErrors == 0)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
// Control unit top with decoder, sequencer, window pointer and trap queue
`timescale 1ns/1ps
`default_nettype none

module controlUnit import cuPkg::*;
(
        input  wire       Clk,
        input  wire       rstN,
        input  word_t     ir,
        input  icc_t      icc,
        input  word_t     wim,
        input  wire       mfc,
        output logic      mfa,
        output logic      memWrite,
        output logic      irLoad,
        output logic      pcLoad,
        output logic      nPcLoad,
        output logic      rfWrite,
        output logic      trapEnter,
        output nPcSel_t   nPcSel,
        output cwp_t      cwp,
        output logic      supervisor,
        output trapType_t trapType
);

        opClass_t  opClass;
        logic      condTrue;
        logic      windowSave;
        logic      windowRestore;
        logic      windowTrap;
        logic      overflow;
        logic      underflow;
        logic      raiseTrap;
        trapType_t raiseType;
        logic      trapTaken;
        logic      pending;
        trapType_t pendingType;

        instrDecode decode
        (
                .ir       (ir),
                .icc      (icc),
                .opClass  (opClass),
                .condTrue (condTrue)
        );

        controlSequencer sequencer
        (
                .Clk           (Clk),
                .rstN          (rstN),
                .opClass       (opClass),
                .condTrue      (condTrue),
                .overflow      (overflow),
                .underflow     (underflow),
                .pending       (pending),
                .pendingType   (pendingType),
                .mfc           (mfc),
                .mfa           (mfa),
                .memWrite      (memWrite),
                .irLoad        (irLoad),
                .pcLoad        (pcLoad),
                .nPcLoad       (nPcLoad),
                .nPcSel        (nPcSel),
                .rfWrite       (rfWrite),
                .supervisor    (supervisor),
                .trapEnter     (trapEnter),
                .trapType      (trapType),
                .windowSave    (windowSave),
                .windowRestore (windowRestore),
                .windowTrap    (windowTrap),
                .raiseTrap     (raiseTrap),
                .raiseType     (raiseType),
                .trapTaken     (trapTaken)
        );

        windowControl windows
        (
                .Clk           (Clk),
                .rstN          (rstN),
                .windowSave    (windowSave),
                .windowRestore (windowRestore),
                .windowTrap    (windowTrap),
                .wim           (wim),
                .cwp           (cwp),
                .overflow      (overflow),
                .underflow     (underflow)
        );

        trapQueue traps
        (
                .Clk         (Clk),
                .rstN        (rstN),
                .raiseTrap   (raiseTrap),
                .raiseType   (raiseType),
                .trapTaken   (trapTaken),
                .pending     (pending),
                .pendingType (pendingType)
        );

endmodule

`default_nettype wire

// ==== logic/controlSequencer.sv ====
// Multi-cycle fetch, execute and trap-entry sequencer driving all control strobes
`timescale 1ns/1ps
`default_nettype none

module controlSequencer import cuPkg::*;
(
        input  wire       Clk,
        input  wire       rstN,
        input  opClass_t  opClass,
        input  wire       condTrue,
        input  wire       overflow,
        input  wire       underflow,
        input  wire       pending,
        input  trapType_t pendingType,
        input  wire       mfc,
        output logic      mfa,
        output logic      memWrite,
        output logic      irLoad,
        output logic      pcLoad,
        output logic      nPcLoad,
        output nPcSel_t   nPcSel,
        output logic      rfWrite,
        output logic      supervisor,
        output logic      trapEnter,
        output trapType_t trapType,
        output logic      windowSave,
        output logic      windowRestore,
        output logic      windowTrap,
        output logic      raiseTrap,
        output trapType_t raiseType,
        output logic      trapTaken
);

        typedef enum logic [3:0] {
                sReset,
                sCheck,
                sFetch,
                sIrLoad,
                sDecode,
                sWindow,
                sWrite,
                sMemory,
                sRaise,
                sPcLoad,
                sNPcLoad,
                sTrapEnter,
                sTrapSavePc,
                sTrapSaveNPc
        } state_t;

        state_t    state;
        nPcSel_t   selReg;
        trapType_t raiseReg;

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        state      <= sReset;
                        selReg     <= nPcIncrement;
                        raiseReg   <= ttNone;
                        supervisor <= 1'b1;
                end
                else
                begin
                        case (state)
                                sReset:  state <= sCheck;      // Queue empty, falls to fetch
                                sCheck:  state <= pending ? sTrapEnter : sFetch;
                                sFetch:
                                begin
                                        if (mfc)
                                                state <= sIrLoad;
                                end
                                sIrLoad: state <= sDecode;
                                sDecode:
                                begin
                                        selReg <= nPcIncrement;
                                        case (opClass)
                                                opCall:
                                                begin
                                                        selReg <= nPcDisplacement;
                                                        state  <= sWrite;
                                                end
                                                opBranch:
                                                begin
                                                        if (condTrue)
                                                                selReg <= nPcDisplacement;
                                                        state <= sPcLoad;
                                                end
                                                opSethi, opAlu: state <= sWrite;
                                                opJmpl:
                                                begin
                                                        selReg <= nPcAluTarget;
                                                        state  <= sWrite;
                                                end
                                                opSave:
                                                begin
                                                        raiseReg <= ttOverflow;
                                                        state    <= overflow ? sRaise : sWindow;
                                                end
                                                opRestore:
                                                begin
                                                        raiseReg <= ttUnderflow;
                                                        state    <= underflow ? sRaise : sWindow;
                                                end
                                                opTicc:
                                                begin
                                                        raiseReg <= ttSoftware;
                                                        state    <= condTrue ? sRaise : sPcLoad;
                                                end
                                                opLoad, opStore: state <= sMemory;
                                                default:
                                                begin
                                                        raiseReg <= ttIllegal;
                                                        state    <= sRaise;
                                                end
                                        endcase
                                end
                                sWindow: state <= sWrite;
                                sWrite:  state <= sPcLoad;
                                sMemory:
                                begin
                                        if (mfc)
                                                state <= (opClass == opLoad) ? sWrite : sPcLoad;
                                end
                                sRaise:   state <= (opClass == opTicc) ? sPcLoad : sCheck;
                                sPcLoad:  state <= sNPcLoad;
                                sNPcLoad: state <= sCheck;
                                sTrapEnter:
                                begin
                                        supervisor <= 1'b1;
                                        selReg     <= nPcTrapVector;
                                        state      <= sTrapSavePc;
                                end
                                sTrapSavePc:  state <= sTrapSaveNPc;
                                sTrapSaveNPc: state <= sPcLoad;
                                default:      state <= sReset;
                        endcase
                end
        end

        assign mfa       = (state == sFetch) || (state == sMemory);
        assign memWrite  = (state == sMemory) && (opClass == opStore);
        assign irLoad    = (state == sIrLoad);
        assign pcLoad    = (state == sPcLoad);
        assign nPcLoad   = (state == sNPcLoad);
        assign nPcSel    = selReg;
        assign rfWrite   = (state == sWrite) || (state == sTrapSavePc) ||
                           (state == sTrapSaveNPc);

        assign trapEnter = (state == sTrapEnter);
        assign trapTaken = trapEnter;               // Pops the entry being reported
        assign trapType  = trapEnter ? pendingType : ttNone;

        assign windowSave    = (state == sWindow) && (opClass == opSave);
        assign windowRestore = (state == sWindow) && (opClass == opRestore);
        assign windowTrap    = trapEnter;

        assign raiseTrap = (state == sRaise);
        assign raiseType = raiseReg;

endmodule

`default_nettype wire

// ==== logic/trapQueue.sv ====
// Pending trap bits with fixed priority pick and clear on trap entry
`timescale 1ns/1ps
`default_nettype none

module trapQueue import cuPkg::*;
(
        input  wire       Clk,
        input  wire       rstN,
        input  wire       raiseTrap,
        input  trapType_t raiseType,
        input  wire       trapTaken,
        output logic      pending,
        output trapType_t pendingType
);

        logic [4:1] pendBits;   // Indexed by trap type

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                        pendBits <= '0;
                else
                begin
                        if (trapTaken)
                                pendBits[pendingType] <= 1'b0;
                        if (raiseTrap)
                                pendBits[raiseType] <= 1'b1;
                end
        end

        always_comb
        begin
                if (pendBits[ttOverflow])
                        pendingType = ttOverflow;
                else if (pendBits[ttUnderflow])
                        pendingType = ttUnderflow;
                else if (pendBits[ttSoftware])
                        pendingType = ttSoftware;
                else if (pendBits[ttIllegal])
                        pendingType = ttIllegal;
                else
                        pendingType = ttNone;
        end

        assign pending = |pendBits;

endmodule

`default_nettype wire

// ==== logic/windowControl.sv ====
// Register window pointer with overflow and underflow checks against the invalid mask
`timescale 1ns/1ps
`default_nettype none

module windowControl import cuPkg::*;
(
        input  wire   Clk,
        input  wire   rstN,
        input  wire   windowSave,
        input  wire   windowRestore,
        input  wire   windowTrap,
        input  word_t wim,
        output cwp_t  cwp,
        output logic  overflow,
        output logic  underflow
);

        cwp_t saveIdx;
        cwp_t restoreIdx;

        // Neighbour windows, wrapping around the ring
        assign saveIdx    = cwp_t'((int'(cwp) + nWindows - 1) % nWindows);
        assign restoreIdx = cwp_t'((int'(cwp) + 1) % nWindows);

        assign overflow  = wim[saveIdx];
        assign underflow = wim[restoreIdx];

        always_ff @(posedge Clk or negedge rstN)
        begin
                if (!rstN)
                        cwp <= '0;
                else if (windowTrap)
                        cwp <= '0;              // Trap entry uses window 0
                else if (windowSave)
                        cwp <= saveIdx;
                else if (windowRestore)
                        cwp <= restoreIdx;
        end

endmodule

`default_nettype wire

// ==== logic/instrDecode.sv ====
// Instruction class decoder and integer condition code evaluation
`timescale 1ns/1ps
`default_nettype none

module instrDecode import cuPkg::*;
(
        input  word_t    ir,
        input  icc_t     icc,
        output opClass_t opClass,
        output logic     condTrue
);

        logic [1:0] op;
        logic [2:0] op2;
        logic [5:0] op3;
        condCode_t  cond;
        logic       baseTrue;

        assign op   = ir[31:30];
        assign op2  = ir[24:22];
        assign op3  = ir[24:19];
        assign cond = ir[28:25];

        always_comb
        begin
                opClass = opIllegal;
                case (op)
                        2'b00:
                        begin
                                if (op2 == op2Branch)
                                        opClass = opBranch;
                                else if (op2 == op2Sethi)
                                        opClass = opSethi;
                        end
                        2'b01: opClass = opCall;
                        2'b10:
                        begin
                                if (op3 == op3Jmpl)
                                        opClass = opJmpl;
                                else if (op3 == op3Save)
                                        opClass = opSave;
                                else if (op3 == op3Restore)
                                        opClass = opRestore;
                                else if (op3 == op3Ticc)
                                        opClass = opTicc;
                                else if (!op3[5])
                                        opClass = opAlu;    // Plain and cc-setting ALU ops
                        end
                        default:
                        begin
                                if (op3[5:3] == 3'b000)
                                        opClass = op3[2] ? opStore : opLoad;
                        end
                endcase
        end

        // Codes 8..15 invert 0..7
        always_comb
        begin
                case (cond[2:0])
                        3'd0: baseTrue = 1'b0;                         // Never
                        3'd1: baseTrue = icc[2];                       // Equal
                        3'd2: baseTrue = icc[2] | (icc[3] ^ icc[1]);   // Less or equal
                        3'd3: baseTrue = icc[3] ^ icc[1];              // Less
                        3'd4: baseTrue = icc[0] | icc[2];              // Unsigned le
                        3'd5: baseTrue = icc[0];                       // Carry set
                        3'd6: baseTrue = icc[3];                       // Negative
                        default: baseTrue = icc[1];                    // Overflow set
                endcase
        end

        assign condTrue = baseTrue ^ cond[3];

endmodule

`default_nettype wire

// ==== logic/cuPkg.sv ====
// Control unit package with word types, class, next-PC and trap enums, opcode constants
`default_nettype none

package cuPkg;

        typedef logic [31:0] word_t;      // Instruction or mask word
        typedef logic [4:0]  cwp_t;       // Current window pointer
        typedef logic [3:0]  icc_t;       // N, Z, V, C from msb down
        typedef logic [3:0]  condCode_t;  // Cond field of branch and ticc

        typedef enum logic [3:0] {
                opCall,
                opBranch,
                opSethi,
                opAlu,
                opJmpl,
                opSave,
                opRestore,
                opTicc,
                opLoad,
                opStore,
                opIllegal
        } opClass_t;

        typedef enum logic [1:0] {
                nPcIncrement,
                nPcDisplacement,
                nPcAluTarget,
                nPcTrapVector
        } nPcSel_t;

        // Lower value wins, ttOverflow first
        typedef enum logic [2:0] {
                ttNone,
                ttOverflow,
                ttUnderflow,
                ttSoftware,
                ttIllegal
        } trapType_t;

        localparam int nWindows = 32;

        localparam logic [5:0] op3Jmpl    = 6'b111000;
        localparam logic [5:0] op3Ticc    = 6'b111010;
        localparam logic [5:0] op3Save    = 6'b111100;
        localparam logic [5:0] op3Restore = 6'b111101;

        localparam logic [2:0] op2Branch  = 3'b010;
        localparam logic [2:0] op2Sethi   = 3'b100;

endpackage

`default_nettype wire
